// ==== verilog/task_unit_settings.svh ====
`ifndef TASK_UNIT_SETTINGS_SVH
`define TASK_UNIT_SETTINGS_SVH

`define TS_WIDTH       32
`define LOCALE_WIDTH   32
`define ARG_WIDTH      64
`define TTYPE_WIDTH    4
`define HEAP_DEPTH     16
`define COUNT_WIDTH    5
`define FIFO_LOG_DEPTH 3
`define CFG_WIDTH      16
`define TTYPE_SPLITTER 4'd15

// Register bus addresses
`define REG_START           8'h10
`define REG_THROTTLE_MARGIN 8'h14
`define REG_SPILL_THRESHOLD 8'h18
`define REG_PRE_ENQ_CONFIG  8'h1c
`define REG_N_TASKS         8'h20
`define REG_LVT             8'h24

`define RST_SPILL_THRESHOLD 16'd12
`define RST_THROTTLE_MARGIN 32'd0
`define RST_DEQ_TOLERANCE   16'd1
`define RST_FIFO_THRESH     16'd0
`define RST_START           1'b0

`endif

// ==== verilog/task_unit_pkg.sv ====
`include "task_unit_settings.svh"

package task_unit_pkg;

   typedef logic [`TS_WIDTH-1:0] ts_t;

   // Timestamp and producer bit lead, so the key sits in the top bits
   typedef struct packed {
      ts_t                       ts;
      logic                      producer;
      logic [`TTYPE_WIDTH-1:0]   ttype;
      logic [`LOCALE_WIDTH-1:0]  locale;
      logic [`ARG_WIDTH-1:0]     args;
      logic                      no_write;
      logic                      no_read;
      logic                      non_spec;
   } task_t;

   typedef enum logic [1:0] {
      NOP,
      ENQ,
      DEQ_MIN,
      REPLACE
   } heap_op_t;

   typedef struct packed {
      logic        wvalid;
      logic [7:0]  waddr;
      logic [31:0] wdata;
   } reg_wr_t;

   typedef struct packed {
      logic       arvalid;
      logic [7:0] araddr;
   } reg_rd_req_t;

   typedef struct packed {
      logic        rvalid;
      logic [31:0] rdata;
   } reg_rd_resp_t;

   typedef struct packed {
      logic                    ready;
      logic                    out_valid;
      logic [`COUNT_WIDTH-1:0] count;
   } heap_status_t;

endpackage

// ==== verilog/task_fifo.sv ====
`timescale 1ns/100ps

module task_fifo #(
   parameter type item_t = logic [7:0],
   parameter int LOG_DEPTH = 3
) (
   input  logic             clk,
   input  logic             rstn,
   input  logic             wr_en,
   input  item_t            wr_data,
   input  logic             rd_en,
   output item_t            rd_data,
   output logic             full,
   output logic             empty,
   output logic [LOG_DEPTH:0] occ
);

   localparam int DEPTH = 2 ** LOG_DEPTH;

   item_t mem [DEPTH];
   logic [LOG_DEPTH:0] wr_ptr;
   logic [LOG_DEPTH:0] rd_ptr;
   logic do_wr;
   logic do_rd;

   assign occ   = wr_ptr - rd_ptr;
   assign full  = (occ == (LOG_DEPTH + 1)'(DEPTH));
   assign empty = (wr_ptr == rd_ptr);
   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   // Head entry always shows on rd_data
   assign rd_data = mem[rd_ptr[LOG_DEPTH-1:0]];

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr[LOG_DEPTH-1:0]] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

endmodule

// ==== verilog/task_heap.sv ====
`timescale 1ns/100ps
`include "task_unit_settings.svh"

module task_heap import task_unit_pkg::*; (
   input  logic         clk,
   input  logic         rstn,
   input  heap_op_t     op,
   input  task_t        in_task,
   output task_t        out_task,
   output heap_status_t status
);

   localparam int DEPTH = `HEAP_DEPTH;

   task_t slots [DEPTH];
   task_t slots_next [DEPTH];
   logic [`COUNT_WIDTH-1:0] count;
   logic ready_q;
   logic do_op;
   logic [DEPTH-1:0] before_enq;
   logic [DEPTH-1:0] before_rep;

   // Equal keys keep arrival order, new task goes behind them
   function automatic logic key_le(task_t a, task_t b);
      return {a.ts, a.producer} <= {b.ts, b.producer};
   endfunction

   assign do_op = ready_q && (op != NOP) &&
                  !(op == ENQ && count == `COUNT_WIDTH'(DEPTH)) &&
                  !((op == DEQ_MIN || op == REPLACE) && count == '0);

   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         before_enq[i] = (i < count) && key_le(slots[i], in_task);
      end
      // Replace compares against the entries left after slot 0 is removed
      for (int i = 0; i < DEPTH - 1; i++) begin
         before_rep[i] = (i + 1 < count) && key_le(slots[i+1], in_task);
      end
      before_rep[DEPTH-1] = 1'b0;
   end

   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         slots_next[i] = slots[i];
      end
      case (op)
         ENQ: begin
            slots_next[0] = before_enq[0] ? slots[0] : in_task;
            for (int i = 1; i < DEPTH; i++) begin
               if (!before_enq[i]) begin
                  slots_next[i] = before_enq[i-1] ? in_task : slots[i-1];
               end
            end
         end
         DEQ_MIN: begin
            for (int i = 0; i < DEPTH - 1; i++) begin
               slots_next[i] = slots[i+1];
            end
         end
         REPLACE: begin
            slots_next[0] = before_rep[0] ? slots[1] : in_task;
            for (int i = 1; i < DEPTH - 1; i++) begin
               if (before_rep[i]) begin
                  slots_next[i] = slots[i+1];
               end else begin
                  slots_next[i] = before_rep[i-1] ? in_task : slots[i];
               end
            end
            slots_next[DEPTH-1] = before_rep[DEPTH-2] ? in_task : slots[DEPTH-1];
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (do_op) begin
         slots <= slots_next;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         count   <= '0;
         ready_q <= 1'b0;
      end else begin
         // One recovery cycle after every accepted operation
         ready_q <= !do_op;
         if (do_op && op == ENQ) begin
            count <= count + 1'b1;
         end else if (do_op && op == DEQ_MIN) begin
            count <= count - 1'b1;
         end
      end
   end

   assign out_task         = slots[0];
   assign status.ready     = ready_q;
   assign status.out_valid = ready_q && (count != '0);
   assign status.count     = count;

endmodule

// ==== verilog/insert_sched.sv ====
`timescale 1ns/100ps
`include "task_unit_settings.svh"

module insert_sched import task_unit_pkg::*; (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  task_enq_valid,
   output logic                  task_enq_ready,
   input  task_t                 task_enq_data,
   input  logic                  coal_child_valid,
   output logic                  coal_child_ready,
   input  task_t                 coal_child_data,
   input  heap_status_t          heap_st,
   input  logic                  deq_take,
   input  logic [`CFG_WIDTH-1:0] deq_tolerance,
   input  logic [`CFG_WIDTH-1:0] fifo_thresh,
   output heap_op_t              heap_op,
   output task_t                 heap_in,
   output logic                  fifo_empty
);

   logic in_open;
   logic fifo_full;
   logic fifo_wr;
   logic fifo_rd;
   task_t fifo_wr_data;
   logic [`FIFO_LOG_DEPTH:0] fifo_occ;
   logic [`CFG_WIDTH-1:0] since_deq;
   logic insert_due;
   logic heap_full;

   // Inputs open together with the heap, one cycle after reset
   always_ff @(posedge clk) begin
      if (!rstn) begin
         in_open <= 1'b0;
      end else begin
         in_open <= 1'b1;
      end
   end

   // Coalescer child has priority over the task port
   assign coal_child_ready = in_open && !fifo_full;
   assign task_enq_ready   = in_open && !fifo_full && !coal_child_valid;
   assign fifo_wr          = (coal_child_valid && coal_child_ready) ||
                             (task_enq_valid && task_enq_ready);
   assign fifo_wr_data     = coal_child_valid ? coal_child_data : task_enq_data;

   task_fifo #(
      .item_t    (task_t),
      .LOG_DEPTH (`FIFO_LOG_DEPTH)
   ) i_pre_enq_fifo (
      .clk     (clk),
      .rstn    (rstn),
      .wr_en   (fifo_wr),
      .wr_data (fifo_wr_data),
      .rd_en   (fifo_rd),
      .rd_data (heap_in),
      .full    (fifo_full),
      .empty   (fifo_empty),
      .occ     (fifo_occ)
   );

   always_ff @(posedge clk) begin
      if (!rstn) begin
         since_deq <= '0;
      end else if (heap_op == DEQ_MIN || heap_op == REPLACE) begin
         since_deq <= '0;
      end else if (since_deq != '1) begin
         since_deq <= since_deq + 1'b1;
      end
   end

   // Hold tasks back to pair them with a dequeue as a replace
   assign insert_due = !fifo_empty &&
                       (deq_take || (deq_tolerance < since_deq) ||
                        (`CFG_WIDTH'(fifo_occ) > fifo_thresh));

   assign heap_full = (heap_st.count == `COUNT_WIDTH'(`HEAP_DEPTH));

   always_comb begin
      heap_op = NOP;
      if (heap_st.ready) begin
         if (insert_due && deq_take) begin
            heap_op = REPLACE;
         end else if (insert_due && !heap_full) begin
            heap_op = ENQ;
         end else if (deq_take) begin
            heap_op = DEQ_MIN;
         end
      end
   end

   assign fifo_rd = (heap_op == ENQ) || (heap_op == REPLACE);

endmodule

// ==== verilog/deq_dispatch.sv ====
`timescale 1ns/100ps
`include "task_unit_settings.svh"

module deq_dispatch import task_unit_pkg::*; (
   input  logic         clk,
   input  logic         rstn,
   input  task_t        heap_out,
   input  heap_status_t heap_st,
   input  logic         started,
   input  ts_t          throttle_margin,
   input  ts_t          gvt,
   output logic         task_deq_valid,
   input  logic         task_deq_ready,
   output task_t        task_deq_data,
   output logic         splitter_deq_valid,
   input  logic         splitter_deq_ready,
   output task_t        splitter_deq_task,
   output logic         deq_take,
   output ts_t          lvt
);

   ts_t throttle_ts;
   ts_t last_deq_ts;
   logic is_splitter;
   logic head_avail;

   // Zero margin disables the throttle
   always_ff @(posedge clk) begin
      if (!rstn) begin
         throttle_ts <= '1;
      end else if (throttle_margin == '0) begin
         throttle_ts <= '1;
      end else begin
         throttle_ts <= gvt + throttle_margin;
      end
   end

   assign is_splitter = (heap_out.ttype == `TTYPE_SPLITTER);
   assign head_avail  = heap_st.ready && heap_st.out_valid;

   assign task_deq_valid     = head_avail && !is_splitter && started &&
                               (heap_out.ts < throttle_ts);
   assign splitter_deq_valid = head_avail && is_splitter;
   assign task_deq_data      = heap_out;
   assign splitter_deq_task  = heap_out;

   assign deq_take = (task_deq_valid && task_deq_ready) ||
                     (splitter_deq_valid && splitter_deq_ready);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         last_deq_ts <= '0;
      end else if (task_deq_valid && task_deq_ready) begin
         last_deq_ts <= heap_out.ts;
      end
   end

   assign lvt = (heap_st.count == '0) ? '1 :
                (heap_st.out_valid ? heap_out.ts : last_deq_ts);

endmodule

// ==== verilog/task_unit_regs.sv ====
`timescale 1ns/100ps
`include "task_unit_settings.svh"

module task_unit_regs import task_unit_pkg::*; (
   input  logic                  clk,
   input  logic                  rstn,
   input  reg_wr_t               reg_wr,
   input  reg_rd_req_t           reg_rd_req,
   output reg_rd_resp_t          reg_rd_resp,
   input  heap_status_t          heap_st,
   input  logic                  fifo_empty,
   input  ts_t                   lvt,
   output logic                  started,
   output ts_t                   throttle_margin,
   output logic [`CFG_WIDTH-1:0] spill_threshold,
   output logic [`CFG_WIDTH-1:0] deq_tolerance,
   output logic [`CFG_WIDTH-1:0] fifo_thresh,
   output logic                  empty,
   output logic                  almost_full,
   output logic                  full
);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         started         <= `RST_START;
         throttle_margin <= `RST_THROTTLE_MARGIN;
         spill_threshold <= `RST_SPILL_THRESHOLD;
         deq_tolerance   <= `RST_DEQ_TOLERANCE;
         fifo_thresh     <= `RST_FIFO_THRESH;
      end else if (reg_wr.wvalid) begin
         case (reg_wr.waddr)
            `REG_START:           started <= reg_wr.wdata[0];
            `REG_THROTTLE_MARGIN: throttle_margin <= reg_wr.wdata;
            `REG_SPILL_THRESHOLD: spill_threshold <= reg_wr.wdata[`CFG_WIDTH-1:0];
            `REG_PRE_ENQ_CONFIG: begin
               deq_tolerance <= reg_wr.wdata[15:0];
               fifo_thresh   <= reg_wr.wdata[31:16];
            end
            default: ;
         endcase
      end
   end

   // Read data follows the request by one cycle
   always_ff @(posedge clk) begin
      if (!rstn) begin
         reg_rd_resp.rvalid <= 1'b0;
      end else begin
         reg_rd_resp.rvalid <= reg_rd_req.arvalid;
         if (reg_rd_req.arvalid) begin
            case (reg_rd_req.araddr)
               `REG_START:           reg_rd_resp.rdata <= 32'(started);
               `REG_THROTTLE_MARGIN: reg_rd_resp.rdata <= throttle_margin;
               `REG_SPILL_THRESHOLD: reg_rd_resp.rdata <= 32'(spill_threshold);
               `REG_PRE_ENQ_CONFIG:  reg_rd_resp.rdata <= {fifo_thresh, deq_tolerance};
               `REG_N_TASKS:         reg_rd_resp.rdata <= 32'(heap_st.count);
               `REG_LVT:             reg_rd_resp.rdata <= lvt;
               default:              reg_rd_resp.rdata <= '0;
            endcase
         end
      end
   end

   // Tasks still waiting in the FIFO keep the unit non-empty
   assign empty       = (heap_st.count == '0) && fifo_empty;
   assign almost_full = (`CFG_WIDTH'(heap_st.count) > spill_threshold);
   assign full        = (heap_st.count == `COUNT_WIDTH'(`HEAP_DEPTH));

endmodule

// ==== verilog/task_unit.sv ====
`timescale 1ns/100ps
`include "task_unit_settings.svh"

module task_unit import task_unit_pkg::*; (
   input  logic         clk,
   input  logic         rstn,
   input  logic         task_enq_valid,
   output logic         task_enq_ready,
   input  task_t        task_enq_data,
   input  logic         coal_child_valid,
   output logic         coal_child_ready,
   input  task_t        coal_child_data,
   output logic         task_deq_valid,
   input  logic         task_deq_ready,
   output task_t        task_deq_data,
   output logic         splitter_deq_valid,
   input  logic         splitter_deq_ready,
   output task_t        splitter_deq_task,
   input  ts_t          gvt,
   input  reg_wr_t      reg_wr,
   input  reg_rd_req_t  reg_rd_req,
   output reg_rd_resp_t reg_rd_resp,
   output ts_t          lvt,
   output logic         empty,
   output logic         almost_full,
   output logic         full
);

   heap_op_t heap_op;
   task_t heap_in;
   task_t heap_out;
   heap_status_t heap_st;
   logic deq_take;
   logic fifo_empty;
   logic started;
   ts_t throttle_margin;
   logic [`CFG_WIDTH-1:0] deq_tolerance;
   logic [`CFG_WIDTH-1:0] fifo_thresh;

   insert_sched i_insert_sched (
      .clk              (clk),
      .rstn             (rstn),
      .task_enq_valid   (task_enq_valid),
      .task_enq_ready   (task_enq_ready),
      .task_enq_data    (task_enq_data),
      .coal_child_valid (coal_child_valid),
      .coal_child_ready (coal_child_ready),
      .coal_child_data  (coal_child_data),
      .heap_st          (heap_st),
      .deq_take         (deq_take),
      .deq_tolerance    (deq_tolerance),
      .fifo_thresh      (fifo_thresh),
      .heap_op          (heap_op),
      .heap_in          (heap_in),
      .fifo_empty       (fifo_empty)
   );

   task_heap i_task_heap (
      .clk      (clk),
      .rstn     (rstn),
      .op       (heap_op),
      .in_task  (heap_in),
      .out_task (heap_out),
      .status   (heap_st)
   );

   deq_dispatch i_deq_dispatch (
      .clk                (clk),
      .rstn               (rstn),
      .heap_out           (heap_out),
      .heap_st            (heap_st),
      .started            (started),
      .throttle_margin    (throttle_margin),
      .gvt                (gvt),
      .task_deq_valid     (task_deq_valid),
      .task_deq_ready     (task_deq_ready),
      .task_deq_data      (task_deq_data),
      .splitter_deq_valid (splitter_deq_valid),
      .splitter_deq_ready (splitter_deq_ready),
      .splitter_deq_task  (splitter_deq_task),
      .deq_take           (deq_take),
      .lvt                (lvt)
   );

   task_unit_regs i_task_unit_regs (
      .clk             (clk),
      .rstn            (rstn),
      .reg_wr          (reg_wr),
      .reg_rd_req      (reg_rd_req),
      .reg_rd_resp     (reg_rd_resp),
      .heap_st         (heap_st),
      .fifo_empty      (fifo_empty),
      .lvt             (lvt),
      .started         (started),
      .throttle_margin (throttle_margin),
      .spill_threshold (),
      .deq_tolerance   (deq_tolerance),
      .fifo_thresh     (fifo_thresh),
      .empty           (empty),
      .almost_full     (almost_full),
      .full            (full)
   );

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
   output logic clk,
   output logic rstn
);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Reset held for 16 rising edges, released on a falling edge
   initial begin
      rstn = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
   end

endmodule

// ==== bench/task_unit_tb.sv ====
`timescale 1ns/100ps
`include "task_unit_settings.svh"

module task_unit_tb import task_unit_pkg::*; ();

   typedef logic [$bits(reg_rd_resp_t)-2:0] word_t;

   logic clk;
   logic rstn;
   logic task_enq_valid;
   logic task_enq_ready;
   task_t task_enq_data;
   logic coal_child_valid;
   logic coal_child_ready;
   task_t coal_child_data;
   logic task_deq_valid;
   logic task_deq_ready;
   task_t task_deq_data;
   logic splitter_deq_valid;
   logic splitter_deq_ready;
   task_t splitter_deq_task;
   ts_t gvt;
   reg_wr_t reg_wr;
   reg_rd_req_t reg_rd_req;
   reg_rd_resp_t reg_rd_resp;
   ts_t lvt;
   logic empty;
   logic almost_full;
   logic full;

   // Reference model keeps tasks in arrival order
   task_t model_q[$];
   ts_t margin_ref;
   ts_t last_task_ts;
   string test_name;

   tb_clock i_clock (
      .clk  (clk),
      .rstn (rstn)
   );

   task_unit i_dut (
      .clk                (clk),
      .rstn               (rstn),
      .task_enq_valid     (task_enq_valid),
      .task_enq_ready     (task_enq_ready),
      .task_enq_data      (task_enq_data),
      .coal_child_valid   (coal_child_valid),
      .coal_child_ready   (coal_child_ready),
      .coal_child_data    (coal_child_data),
      .task_deq_valid     (task_deq_valid),
      .task_deq_ready     (task_deq_ready),
      .task_deq_data      (task_deq_data),
      .splitter_deq_valid (splitter_deq_valid),
      .splitter_deq_ready (splitter_deq_ready),
      .splitter_deq_task  (splitter_deq_task),
      .gvt                (gvt),
      .reg_wr             (reg_wr),
      .reg_rd_req         (reg_rd_req),
      .reg_rd_resp        (reg_rd_resp),
      .lvt                (lvt),
      .empty              (empty),
      .almost_full        (almost_full),
      .full               (full)
   );

   // Smallest key wins and equal keys go by arrival
   function automatic int min_index();
      int idx;
      idx = 0;
      for (int i = 1; i < model_q.size(); i++) begin
         if ({model_q[i].ts, model_q[i].producer} <
             {model_q[idx].ts, model_q[idx].producer}) begin
            idx = i;
         end
      end
      return idx;
   endfunction

   function automatic task_t expected_next();
      return model_q[min_index()];
   endfunction

   function automatic task_t random_task(input logic [`TTYPE_WIDTH-1:0] ttype, input ts_t ts);
      task_t t;
      t.ts       = ts;
      t.producer = 1'($urandom_range(0, 1));
      t.ttype    = ttype;
      t.locale   = $urandom;
      t.args     = {$urandom, $urandom};
      t.no_write = 1'($urandom_range(0, 1));
      t.no_read  = 1'($urandom_range(0, 1));
      t.non_spec = 1'($urandom_range(0, 1));
      return t;
   endfunction

   function automatic logic [`TTYPE_WIDTH-1:0] plain_type();
      return `TTYPE_WIDTH'($urandom_range(0, `TTYPE_SPLITTER - 1));
   endfunction

   task automatic stop_run();
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic report_failure(input string why);
      $display("%s: %s", test_name, why);
      stop_run();
   endtask

   task automatic compare_task(input string what, input task_t exp, input task_t act);
      if (exp !== act) begin
         $display("MISMATCH %s %s expected %h actual %h", test_name, what, exp, act);
         stop_run();
      end
   endtask

   task automatic compare_word(input string what, input word_t exp, input word_t act);
      if (exp !== act) begin
         $display("MISMATCH %s %s expected %h actual %h", test_name, what, exp, act);
         stop_run();
      end
   endtask

   task automatic write_reg(input logic [7:0] addr, input word_t data);
      @(negedge clk);
      reg_wr = '{wvalid: 1'b1, waddr: addr, wdata: data};
      if (addr == `REG_THROTTLE_MARGIN) begin
         margin_ref = data;
      end
      @(negedge clk);
      reg_wr.wvalid = 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, output word_t data);
      int n;
      @(negedge clk);
      reg_rd_req = '{arvalid: 1'b1, araddr: addr};
      @(negedge clk);
      reg_rd_req.arvalid = 1'b0;
      #30;
      n = 0;
      while (!reg_rd_resp.rvalid) begin
         if (n == 4) begin
            report_failure("register read got no response");
         end
         n++;
         @(negedge clk);
         #30;
      end
      data = reg_rd_resp.rdata;
   endtask

   // Called at a sample point with valid already driven
   task automatic await_accept(input logic child, input task_t t);
      int n;
      n = 0;
      while (!(child ? coal_child_ready : task_enq_ready)) begin
         if (n == 500) begin
            report_failure("enqueue ready stayed low");
         end
         n++;
         @(negedge clk);
         #30;
      end
      model_q.push_back(t);
      @(negedge clk);
      if (child) begin
         coal_child_valid = 1'b0;
      end else begin
         task_enq_valid = 1'b0;
      end
   endtask

   task automatic send_task(input logic child, input task_t t);
      @(negedge clk);
      if (child) begin
         coal_child_valid = 1'b1;
         coal_child_data  = t;
      end else begin
         task_enq_valid = 1'b1;
         task_enq_data  = t;
      end
      #30;
      await_accept(child, t);
   endtask

   task automatic wait_count(input int expected);
      word_t rd;
      int n;
      n = 0;
      read_reg(`REG_N_TASKS, rd);
      while (rd != word_t'(expected)) begin
         if (n == 100) begin
            report_failure("heap count never reached the enqueued total");
         end
         n++;
         read_reg(`REG_N_TASKS, rd);
      end
   endtask

   task automatic wait_model_size(input int expected);
      int n;
      n = 0;
      @(negedge clk);
      #30;
      while (model_q.size() != expected || (expected == 0 && !empty)) begin
         if (n == 2000) begin
            report_failure("expected dequeues did not happen");
         end
         n++;
         @(negedge clk);
         #30;
      end
   endtask

   task automatic wait_drained();
      wait_model_size(0);
      @(negedge clk);
      task_deq_ready     = 1'b0;
      splitter_deq_ready = 1'b0;
   endtask

   task automatic check_transfer(input task_t act);
      if (model_q.size() == 0) begin
         report_failure("dequeue with no task left in the model");
      end
      compare_task("dequeued task", expected_next(), act);
      model_q.delete(min_index());
   endtask

   initial begin : dequeue_monitor
      logic lvt_due;
      ts_t exp_lvt;
      ts_t bound;
      lvt_due = 1'b0;
      forever begin
         @(negedge clk);
         #40;
         if (rstn) begin
            // Recovery cycle after a dequeue shows the last commit-queue timestamp
            if (lvt_due) begin
               exp_lvt = (model_q.size() == 0) ? '1 : last_task_ts;
               compare_word("lvt after dequeue", exp_lvt, lvt);
            end
            lvt_due = 1'b0;
            bound = gvt + margin_ref;
            if (task_deq_valid && task_deq_data.ttype == `TTYPE_SPLITTER) begin
               report_failure("splitter task offered on the commit-queue port");
            end
            if (splitter_deq_valid && splitter_deq_task.ttype != `TTYPE_SPLITTER) begin
               report_failure("ordinary task offered on the splitter port");
            end
            if (task_deq_valid && margin_ref != '0 && task_deq_data.ts >= bound) begin
               report_failure("task offered at or above the throttle bound");
            end
            if (task_deq_valid && task_deq_ready) begin
               check_transfer(task_deq_data);
               last_task_ts = task_deq_data.ts;
               lvt_due = 1'b1;
            end
            if (splitter_deq_valid && splitter_deq_ready) begin
               check_transfer(splitter_deq_task);
               lvt_due = 1'b1;
            end
         end
      end
   end

   initial begin : stimulus
      word_t rd;
      task_t t_child;
      task_t t_port;
      ts_t throttle_list [6];
      int n;
      task_enq_valid     = 1'b0;
      task_enq_data      = '0;
      coal_child_valid   = 1'b0;
      coal_child_data    = '0;
      task_deq_ready     = 1'b0;
      splitter_deq_ready = 1'b0;
      gvt                = '0;
      reg_wr             = '0;
      reg_rd_req         = '0;
      margin_ref         = '0;
      last_task_ts       = '0;
      test_name          = "reset";
      void'($urandom(32'h0c7d13c8));

      @(negedge clk);
      #10;
      n = 0;
      while (!rstn) begin
         if (n == 40) begin
            report_failure("reset was never released");
         end
         n++;
         @(negedge clk);
         #10;
      end
      // Inputs stay closed until the heap is ready
      compare_word("task port ready", 0, word_t'(task_enq_ready));
      compare_word("child ready", 0, word_t'(coal_child_ready));
      compare_word("rvalid", 0, word_t'(reg_rd_resp.rvalid));
      compare_word("empty", 1, word_t'(empty));
      repeat (50) begin
         @(negedge clk);
         #30;
         if (task_deq_valid || splitter_deq_valid) begin
            report_failure("dequeue valid rose with start low and no tasks");
         end
      end
      read_reg(`REG_N_TASKS, rd);
      compare_word("task count", 0, rd);

      test_name = "ordering";
      for (int i = 0; i < 12; i++) begin
         send_task(1'b0, random_task(plain_type(), $urandom));
      end
      wait_count(12);
      compare_word("valid before start", 0, word_t'(task_deq_valid));
      write_reg(`REG_START, 1);
      repeat (5) begin
         #30;
         compare_word("held valid", 1, word_t'(task_deq_valid));
         compare_task("held head", expected_next(), task_deq_data);
         @(negedge clk);
      end
      task_deq_ready = 1'b1;
      wait_drained();
      read_reg(`REG_LVT, rd);
      compare_word("lvt when empty", '1, rd);

      test_name = "routing";
      for (int i = 0; i < 6; i++) begin
         send_task(i[0], random_task(`TTYPE_SPLITTER, ts_t'($urandom_range(0, 5000))));
      end
      wait_count(6);
      // Start is still high here, so only the task type keeps the commit port closed
      compare_word("commit valid with splitter head", 0, word_t'(task_deq_valid));
      write_reg(`REG_START, 0);
      @(negedge clk);
      splitter_deq_ready = 1'b1;
      wait_drained();

      test_name = "priority";
      @(negedge clk);
      t_child          = random_task(plain_type(), $urandom);
      t_port           = random_task(plain_type(), $urandom);
      coal_child_valid = 1'b1;
      coal_child_data  = t_child;
      task_enq_valid   = 1'b1;
      task_enq_data    = t_port;
      #30;
      compare_word("child ready", 1, word_t'(coal_child_ready));
      compare_word("task port ready", 0, word_t'(task_enq_ready));
      model_q.push_back(t_child);
      @(negedge clk);
      coal_child_valid = 1'b0;
      #30;
      await_accept(1'b0, t_port);
      wait_count(2);
      write_reg(`REG_START, 1);
      @(negedge clk);
      task_deq_ready = 1'b1;
      wait_drained();

      test_name = "throttle";
      write_reg(`REG_THROTTLE_MARGIN, 500);
      @(negedge clk);
      gvt = 32'd1000;
      throttle_list = '{32'd1100, 32'd1499, 32'd1200, 32'd1500, 32'd2000, 32'd1700};
      for (int i = 0; i < 6; i++) begin
         send_task(1'b0, random_task(plain_type(), throttle_list[i]));
      end
      wait_count(6);
      @(negedge clk);
      task_deq_ready = 1'b1;
      wait_model_size(3);
      repeat (30) begin
         @(negedge clk);
         #30;
         if (task_deq_valid) begin
            report_failure("task beyond the throttle bound was offered");
         end
      end
      t_port = expected_next();
      compare_word("lvt under throttle", t_port.ts, lvt);
      @(negedge clk);
      gvt = 32'd3000;
      wait_drained();

      test_name = "flags";
      write_reg(`REG_THROTTLE_MARGIN, 0);
      write_reg(`REG_START, 0);
      write_reg(`REG_SPILL_THRESHOLD, 5);
      for (int i = 1; i <= `HEAP_DEPTH; i++) begin
         send_task(i[0], random_task(plain_type(), $urandom));
         wait_count(model_q.size());
         compare_word("almost_full", word_t'(i > 5), word_t'(almost_full));
         compare_word("full", word_t'(i == `HEAP_DEPTH), word_t'(full));
      end
      read_reg(`REG_N_TASKS, rd);
      compare_word("task count", `HEAP_DEPTH, rd);
      write_reg(`REG_START, 1);
      @(negedge clk);
      task_deq_ready = 1'b1;
      wait_drained();

      $display("NO ERRORS");
      $finish;
   end

endmodule

// ==== task_unit.f ====
+incdir+verilog
verilog/task_unit_pkg.sv
verilog/task_fifo.sv
verilog/task_heap.sv
verilog/insert_sched.sv
verilog/deq_dispatch.sv
verilog/task_unit_regs.sv
verilog/task_unit.sv
bench/tb_clock.sv
bench/task_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the task unit testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
   -f task_unit.f --top-module task_unit_tb -o task_unit_sim &&
./obj_dir/task_unit_sim ||
{ echo "task unit simulation failed"; exit 1; }
